// ==== dv/dcache_checker.sv ====
`timescale 1ns/1ps

module dcache_checker import cache_geom_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic            addr_ok,
    input  logic            data_ok,
    input  word_t           rdata,
    input  logic            bus_valid,
    input  logic            bus_write,
    input  word_t           bus_addr,
    input  logic            bus_ready,
    input  logic            bus_last,
    input  logic            idle_check,
    input  logic            test_start,
    input  logic            test_end,
    input  logic [8*24-1:0] test_name,
    input  word_t           cur_addr,
    input  logic            check_data,
    input  word_t           exp_data,
    input  int              exp_rd,
    input  int              exp_wr,
    input  logic            report,
    output int              fail_count
);

    int    pass_count;
    int    rd_bursts;
    int    wr_bursts;
    int    beats;
    int    test_errs;
    logic  got_resp;
    word_t got_data;
    word_t burst_addr;
    logic  burst_open;
    logic  burst_write;
    logic  last_seen;

    initial begin
        fail_count = 0;
        pass_count = 0;
        beats = 0;
        burst_open = 1'b0;
        burst_write = 1'b0;
        last_seen = 1'b0;
    end

    // sampled mid-cycle, where DUT outputs and bus inputs are settled
    always @(negedge clk) begin
        if (test_start) begin
            rd_bursts = 0;
            wr_bursts = 0;
            test_errs = 0;
            got_resp = 1'b0;
            got_data = '0;
        end
        if (!resetn) begin
            if (idle_check && (!addr_ok || data_ok || bus_valid)) begin
                $display("%0s: outputs not idle after reset (addr_ok=%b data_ok=%b bus_valid=%b)",
                         test_name, addr_ok, data_ok, bus_valid);
                test_errs++;
            end
            if (data_ok && !got_resp) begin
                got_resp = 1'b1;
                got_data = rdata;
            end
            // a burst closes when bus_valid drops or the direction turns
            if (burst_open && (!bus_valid || bus_write != burst_write)) begin
                if (beats != words_per_line) begin
                    $display("%0s: burst ended after %0d beats", test_name, beats);
                    test_errs++;
                end
                if (!last_seen) begin
                    $display("%0s: burst ended without bus_last", test_name);
                    test_errs++;
                end
                if (burst_write) begin
                    wr_bursts++;
                end else begin
                    rd_bursts++;
                end
                burst_open = 1'b0;
            end
            if (bus_valid && !burst_open) begin
                burst_open = 1'b1;
                burst_write = bus_write;
                burst_addr = bus_addr;
                beats = 0;
                last_seen = 1'b0;
                if (bus_addr[5:0] != 6'd0) begin
                    $display("%0s: burst address %h is not a line base", test_name, bus_addr);
                    test_errs++;
                end
                if (!bus_write && bus_addr != {cur_addr[31:6], 6'd0}) begin
                    $display("Mismatch %0s read burst address: expected %h, actual %h",
                             test_name, {cur_addr[31:6], 6'd0}, bus_addr);
                    test_errs++;
                end
                if (bus_write && rd_bursts != 0) begin
                    $display("%0s: write burst came after the refill", test_name);
                    test_errs++;
                end
            end else if (bus_valid && bus_addr != burst_addr) begin
                $display("%0s: bus address changed inside a burst", test_name);
                test_errs++;
            end
            if (bus_valid && bus_ready) begin
                if (last_seen) begin
                    $display("%0s: beat after bus_last", test_name);
                    test_errs++;
                end
                beats++;
                if (bus_last) begin
                    last_seen = 1'b1;
                end
            end
        end
        if (test_end) begin
            if (check_data && !got_resp) begin
                $display("%0s: load returned no data", test_name);
                test_errs++;
            end else if (check_data && got_data != exp_data) begin
                $display("Mismatch %0s: expected %h, actual %h", test_name, exp_data, got_data);
                test_errs++;
            end
            if (rd_bursts != exp_rd) begin
                $display("Mismatch %0s read bursts: expected %0d, actual %0d",
                         test_name, exp_rd, rd_bursts);
                test_errs++;
            end
            if (wr_bursts != exp_wr) begin
                $display("Mismatch %0s write bursts: expected %0d, actual %0d",
                         test_name, exp_wr, wr_bursts);
                test_errs++;
            end
            if (test_errs == 0) begin
                $display("%0s: pass", test_name);
                pass_count++;
            end else begin
                $display("%0s: FAIL", test_name);
                fail_count++;
            end
        end
        if (report) begin
            $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        end
    end

endmodule

// ==== dv/dcache_stimulus.txt ====
# name  addr  strobe  wdata  expected_load  read_bursts  write_bursts  random_ready
# hex fields except the last three; expected_load is ignored for stores
ld_miss           00000048 0 00000000 5A5A0048 1 0 0
ld_same_line      0000007C 0 00000000 5A5A007C 0 0 0
st_low_half       00000048 3 DEADBEEF 00000000 0 0 0
ld_after_st_low   00000048 0 00000000 5A5ABEEF 0 0 0
st_top_byte       00000048 8 11223344 00000000 0 0 0
ld_after_st_top   00000048 0 00000000 115ABEEF 0 0 0
ld_line_a         00000140 0 00000000 5A5A0140 1 0 0
st_line_b_w0      00002140 F B0B0B0B0 00000000 1 0 0
st_line_b_w15     0000217C F B1B1B1B1 00000000 0 0 0
ld_touch_a        00000144 0 00000000 5A5A0144 0 0 0
ld_line_c_evict_b 00004140 0 00000000 5A5A4140 1 1 0
ld_b_w0_again     00002140 0 00000000 B0B0B0B0 1 0 0
ld_b_w15_again    0000217C 0 00000000 B1B1B1B1 0 0 0
ld_b_w5_again     00002154 0 00000000 5A5A2154 0 0 0
bp_st_line_d      00006140 F CAFEF00D 00000000 1 0 1
bp_ld_line_e      00008140 0 00000000 5A5A8140 1 0 1
bp_ld_line_f      0000A140 0 00000000 5A5AA140 1 1 1
bp_ld_line_d      00006140 0 00000000 CAFEF00D 1 0 1
bp_ld_set9_miss   00002240 0 00000000 5A5A2240 1 0 1
bp_ld_set9_hit    0000227C 0 00000000 5A5A227C 0 0 1

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import cache_geom_pkg::*; ();

    localparam int wait_limit = 4000;

    logic            clk;
    logic            resetn;
    logic            req_valid;
    word_t           req_addr;
    strobe_t         req_strobe;
    word_t           req_wdata;
    logic            addr_ok;
    logic            data_ok;
    word_t           rdata;
    logic            bus_valid;
    logic            bus_write;
    word_t           bus_addr;
    word_t           bus_wdata;
    logic            bus_ready;
    logic            bus_last;
    word_t           bus_rdata;

    logic            idle_check;
    logic            test_start;
    logic            test_end;
    logic [8*24-1:0] test_name;
    word_t           cur_addr;
    logic            check_data;
    word_t           exp_data;
    int              exp_rd;
    int              exp_wr;
    logic            report;
    int              fail_count;

    logic            run_error;
    logic            rand_ready;
    logic [15:0]     lfsr;
    logic [3:0]      beat_idx;
    word_t           mem [16384];

    dcache_top DUT (
        .clk        (clk),
        .resetn     (resetn),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_strobe (req_strobe),
        .req_wdata  (req_wdata),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .bus_valid  (bus_valid),
        .bus_write  (bus_write),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_ready  (bus_ready),
        .bus_last   (bus_last),
        .bus_rdata  (bus_rdata)
    );

    dcache_checker u_checker (
        .clk        (clk),
        .resetn     (resetn),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .bus_valid  (bus_valid),
        .bus_write  (bus_write),
        .bus_addr   (bus_addr),
        .bus_ready  (bus_ready),
        .bus_last   (bus_last),
        .idle_check (idle_check),
        .test_start (test_start),
        .test_end   (test_end),
        .test_name  (test_name),
        .cur_addr   (cur_addr),
        .check_data (check_data),
        .exp_data   (exp_data),
        .exp_rd     (exp_rd),
        .exp_wr     (exp_wr),
        .report     (report),
        .fail_count (fail_count)
    );

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory model counts beats mid-cycle and drives new bus inputs after the edge
    initial begin
        beat_idx = '0;
        forever begin
            @(negedge clk);
            if (bus_valid && bus_ready) begin
                if (bus_write) begin
                    mem[{bus_addr[15:6], beat_idx}] = bus_wdata;
                end
                beat_idx = beat_idx + 4'd1;
            end
            @(posedge clk);
            #1;
            if (rand_ready) begin
                lfsr = lfsr_next(lfsr);
                bus_ready = lfsr[0];
            end else begin
                bus_ready = 1'b1;
            end
            bus_last = bus_ready && (beat_idx == 4'd15);
            bus_rdata = mem[{bus_addr[15:6], beat_idx}];
        end
    end

    task automatic start_test(input logic [8*24-1:0] name, input word_t a, input logic ld,
                              input word_t exp, input int rd, input int wr);
        test_name = name;
        cur_addr = a;
        check_data = ld;
        exp_data = exp;
        exp_rd = rd;
        exp_wr = wr;
        test_start = 1'b1;
        @(posedge clk);
        #1;
        test_start = 1'b0;
    endtask

    task automatic close_test;
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    task automatic run_request(input word_t a, input strobe_t s, input word_t d);
        int waited;
        req_valid = 1'b1;
        req_addr = a;
        req_strobe = s;
        req_wdata = d;
        waited = 0;
        while (!addr_ok && waited < wait_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!addr_ok) begin
            $display("timeout: request to %h was never accepted", a);
            run_error = 1'b1;
            req_valid = 1'b0;
            return;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        waited = 0;
        while (!data_ok && waited < wait_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!data_ok) begin
            $display("timeout: request to %h got no data_ok", a);
            run_error = 1'b1;
        end
    endtask

    task automatic finish_run;
        report = 1'b1;
        @(posedge clk);
        #1;
        report = 1'b0;
        @(posedge clk);
        if (!run_error && fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    initial begin
        int              fd;
        int              n;
        string           line;
        logic [8*24-1:0] tname;
        word_t           taddr;
        strobe_t         tstrb;
        word_t           twdata;
        word_t           texp;
        int              trd;
        int              twr;
        int              trdy;
        resetn = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_strobe = '0;
        req_wdata = '0;
        bus_ready = 1'b0;
        bus_last = 1'b0;
        bus_rdata = '0;
        idle_check = 1'b0;
        test_start = 1'b0;
        test_end = 1'b0;
        test_name = '0;
        cur_addr = '0;
        check_data = 1'b0;
        exp_data = '0;
        exp_rd = 0;
        exp_wr = 0;
        report = 1'b0;
        run_error = 1'b0;
        rand_ready = 1'b0;
        lfsr = 16'd30213;
        for (int i = 0; i < 16384; i++) begin
            mem[i] = word_t'(i * 4) ^ 32'h5A5A_0000;
        end

        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b0;

        start_test("reset_state", '0, 1'b0, '0, 0, 0);
        idle_check = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        idle_check = 1'b0;
        close_test();

        fd = $fopen("dv/dcache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/dcache_stimulus.txt");
            run_error = 1'b1;
        end
        while (!run_error && !$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %d %d %d",
                        tname, taddr, tstrb, twdata, texp, trd, twr, trdy);
            if (n != 8) begin
                $display("malformed stimulus line: %0s", line);
                run_error = 1'b1;
                break;
            end
            rand_ready = (trdy != 0);
            start_test(tname, taddr, tstrb == '0, texp, trd, twr);
            run_request(taddr, tstrb, twdata);
            if (run_error) begin
                break;
            end
            close_test();
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        finish_run();
    end

endmodule

// ==== files.f ====
hw/cache_geom_pkg.sv
hw/cache_bus_pkg.sv
hw/cache_ifc.sv
hw/sync_ram.sv
hw/cache_way.sv
hw/request_stage.sv
hw/miss_ctrl.sv
hw/dcache_top.sv
dv/dcache_checker.sv
dv/tb_top.sv

// ==== hw/cache_bus_pkg.sv ====
package cache_bus_pkg;

    import cache_geom_pkg::*;

    // request as held between accept and compare
    typedef struct packed {
        cache_addr_t addr;
        // nonzero means store
        strobe_t     strobe;
        word_t       wdata;
    } cpu_req_t;

    typedef enum logic [1:0] {
        ms_idle,
        ms_writeback,
        ms_refill,
        ms_replay
    } miss_state_t;

endpackage

// ==== hw/cache_geom_pkg.sv ====
package cache_geom_pkg;

    localparam int way_num = 2;
    localparam int set_num = 128;
    localparam int words_per_line = 16;
    localparam int bytes_per_word = 4;

    localparam int offset_bits = $clog2(words_per_line);
    localparam int index_bits = $clog2(set_num);
    localparam int align_bits = $clog2(bytes_per_word);
    localparam int tag_bits = 32 - index_bits - offset_bits - align_bits;
    localparam int way_bits = $clog2(way_num);
    // one entry per word of every line in a way
    localparam int data_depth = set_num * words_per_line;

    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [index_bits-1:0] index_t;
    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [31:0] word_t;
    typedef logic [bytes_per_word-1:0] strobe_t;
    typedef logic [way_bits-1:0] way_sel_t;

    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [align_bits-1:0] align;
    } cache_addr_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } meta_t;

    typedef struct packed {
        logic  hit;
        logic  victim_valid;
        logic  victim_dirty;
        tag_t  victim_tag;
        word_t rdata;
    } way_result_t;

endpackage

// ==== hw/cache_ifc.sv ====
`timescale 1ns/1ps

// request stage to the ways
interface lookup_if import cache_geom_pkg::*; ();
    logic        lookup_en;
    cache_addr_t lookup_addr;
    // held request, consumed in the compare cycle
    strobe_t     lookup_strobe;
    word_t       lookup_wdata;
    logic        compare_en;
    logic        store_ok;

    modport source (
        output lookup_en, lookup_addr, lookup_strobe, lookup_wdata, compare_en, store_ok
    );
    modport way (
        input lookup_en, lookup_addr, lookup_strobe, lookup_wdata, compare_en, store_ok
    );
endinterface

// miss controller to the ways
interface refill_if import cache_geom_pkg::*; ();
    way_sel_t refill_way;
    index_t   refill_index;
    offset_t  refill_offset;
    logic     refill_read;
    logic     refill_write;
    word_t    refill_wdata;
    logic     set_meta;
    tag_t     new_tag;
    logic     new_dirty;

    modport ctrl (
        output refill_way, refill_index, refill_offset, refill_read, refill_write,
        output refill_wdata, set_meta, new_tag, new_dirty
    );
    modport way (
        input refill_way, refill_index, refill_offset, refill_read, refill_write,
        input refill_wdata, set_meta, new_tag, new_dirty
    );
endinterface

// ==== hw/cache_way.sv ====
`timescale 1ns/1ps

module cache_way import cache_geom_pkg::*; #(
    parameter way_sel_t way_id = '0
) (
    input  logic        clk,
    input  logic        resetn,
    lookup_if.way       lookup,
    refill_if.way       refill,
    output way_result_t result
);

    index_t                        sweep;
    cache_addr_t                   cmp_addr;
    logic [set_num-1:0]            dirty;
    logic                          mine;
    logic                          fill_rd;
    logic                          fill_wr;
    logic                          fill_meta;
    logic                          hit;
    logic                          store_hit;
    logic                          meta_en;
    strobe_t                       meta_we;
    index_t                        meta_addr;
    meta_t                         meta_wdata;
    meta_t                         meta_q;
    logic                          data_en;
    strobe_t                       data_we;
    logic [$clog2(data_depth)-1:0] data_addr;
    word_t                         data_wdata;
    word_t                         data_q;

    assign mine = refill.refill_way == way_id;
    assign fill_rd = mine & refill.refill_read;
    assign fill_wr = mine & refill.refill_write;
    assign fill_meta = mine & refill.set_meta;

    // walks the sets while reset is held
    always_ff @(posedge clk) begin
        if (resetn) begin
            sweep <= sweep + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup.lookup_en) begin
            cmp_addr <= lookup.lookup_addr;
        end
    end

    assign meta_en = resetn | fill_meta | lookup.lookup_en;
    assign meta_we = (resetn | fill_meta) ? '1 : '0;
    assign meta_addr = resetn ? sweep :
                       fill_meta ? refill.refill_index : lookup.lookup_addr.index;
    assign meta_wdata = resetn ? '0 : {1'b1, refill.new_tag};

    sync_ram #(.depth(set_num), .payload_t(meta_t)) u_meta (
        .clk   (clk),
        .en    (meta_en),
        .we    (meta_we),
        .addr  (meta_addr),
        .wdata (meta_wdata),
        .rdata (meta_q)
    );

    assign hit = lookup.compare_en & meta_q.valid & (meta_q.tag == cmp_addr.tag);
    assign store_hit = lookup.store_ok & hit;

    assign data_en = lookup.lookup_en | store_hit | fill_rd | fill_wr;
    assign data_we = fill_wr ? '1 : (store_hit ? lookup.lookup_strobe : '0);
    assign data_addr = (fill_rd | fill_wr) ? {refill.refill_index, refill.refill_offset} :
                       store_hit ? {cmp_addr.index, cmp_addr.offset} :
                       {lookup.lookup_addr.index, lookup.lookup_addr.offset};
    assign data_wdata = fill_wr ? refill.refill_wdata : lookup.lookup_wdata;

    sync_ram #(.depth(data_depth), .payload_t(word_t)) u_data (
        .clk   (clk),
        .en    (data_en),
        .we    (data_we),
        .addr  (data_addr),
        .wdata (data_wdata),
        .rdata (data_q)
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            dirty <= '0;
        end else if (store_hit) begin
            dirty[cmp_addr.index] <= 1'b1;
        end else if (fill_meta) begin
            dirty[refill.refill_index] <= refill.new_dirty;
        end
    end

    assign result.hit = hit;
    assign result.victim_valid = meta_q.valid;
    assign result.victim_dirty = dirty[cmp_addr.index];
    assign result.victim_tag = meta_q.tag;
    assign result.rdata = data_q;

endmodule

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top import cache_geom_pkg::*; import cache_bus_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  logic    req_valid,
    input  word_t   req_addr,
    input  strobe_t req_strobe,
    input  word_t   req_wdata,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,
    output logic    bus_valid,
    output logic    bus_write,
    output word_t   bus_addr,
    output word_t   bus_wdata,
    input  logic    bus_ready,
    input  logic    bus_last,
    input  word_t   bus_rdata
);

    lookup_if lookup_bus ();
    refill_if refill_bus ();

    cpu_req_t                  held;
    logic                      any_hit;
    logic                      replay;
    way_result_t [way_num-1:0] results;

    request_stage u_req (
        .clk        (clk),
        .resetn     (resetn),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_strobe (req_strobe),
        .req_wdata  (req_wdata),
        .any_hit    (any_hit),
        .replay     (replay),
        .lookup     (lookup_bus.source),
        .held       (held),
        .addr_ok    (addr_ok)
    );

    for (genvar w = 0; w < way_num; w++) begin : g_way
        cache_way #(.way_id(way_sel_t'(w))) u_way (
            .clk    (clk),
            .resetn (resetn),
            .lookup (lookup_bus.way),
            .refill (refill_bus.way),
            .result (results[w])
        );
    end

    miss_ctrl u_miss (
        .clk        (clk),
        .resetn     (resetn),
        .held       (held),
        .compare_en (lookup_bus.compare_en),
        .results    (results),
        .refill     (refill_bus.ctrl),
        .any_hit    (any_hit),
        .replay     (replay),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .bus_valid  (bus_valid),
        .bus_write  (bus_write),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_ready  (bus_ready),
        .bus_last   (bus_last),
        .bus_rdata  (bus_rdata)
    );

endmodule

// ==== hw/miss_ctrl.sv ====
`timescale 1ns/1ps

module miss_ctrl import cache_geom_pkg::*; import cache_bus_pkg::*; (
    input  logic                      clk,
    input  logic                      resetn,
    input  cpu_req_t                  held,
    input  logic                      compare_en,
    input  way_result_t [way_num-1:0] results,
    refill_if.ctrl                    refill,
    output logic                      any_hit,
    output logic                      replay,
    output logic                      data_ok,
    output word_t                     rdata,
    output logic                      bus_valid,
    output logic                      bus_write,
    output word_t                     bus_addr,
    output word_t                     bus_wdata,
    input  logic                      bus_ready,
    input  logic                      bus_last,
    input  word_t                     bus_rdata
);

    miss_state_t        state;
    logic [set_num-1:0] plru;
    logic [way_num-1:0] hit_vec;
    way_sel_t           hit_way;
    way_sel_t           pick_way;
    way_sel_t           vic_way;
    tag_t               vic_tag;
    offset_t            offset;
    logic               wb_primed;
    logic               miss;
    logic               beat;
    logic               fill_done;
    index_t             idx;
    cache_addr_t        line_addr;

    assign idx = held.addr.index;

    for (genvar w = 0; w < way_num; w++) begin : g_hit
        assign hit_vec[w] = results[w].hit;
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < way_num; w++) begin
            if (hit_vec[w]) begin
                hit_way = way_sel_t'(w);
            end
        end
    end

    assign any_hit = |hit_vec;
    assign data_ok = any_hit;
    assign rdata = results[hit_way].rdata;
    assign miss = compare_en & ~any_hit;
    assign pick_way = plru[idx];

    assign beat = bus_valid & bus_ready;
    assign fill_done = (state == ms_refill) & beat & bus_last;

    // writeback offers the word already sitting on the array output
    assign bus_valid = (state == ms_refill) | ((state == ms_writeback) & wb_primed);
    assign bus_write = state == ms_writeback;
    assign bus_wdata = results[vic_way].rdata;

    always_comb begin
        line_addr.tag = (state == ms_writeback) ? vic_tag : held.addr.tag;
        line_addr.index = idx;
        line_addr.offset = '0;
        line_addr.align = '0;
    end
    assign bus_addr = line_addr;

    assign refill.refill_way = vic_way;
    assign refill.refill_index = idx;
    assign refill.refill_offset = offset;
    assign refill.refill_read = (state == ms_writeback) & (~wb_primed | (beat & ~bus_last));
    assign refill.refill_write = (state == ms_refill) & beat;
    assign refill.refill_wdata = bus_rdata;
    assign refill.set_meta = fill_done;
    assign refill.new_tag = held.addr.tag;
    assign refill.new_dirty = 1'b0;

    assign replay = state == ms_replay;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= ms_idle;
            offset <= '0;
            wb_primed <= 1'b0;
        end else begin
            case (state)
                ms_idle: begin
                    if (miss) begin
                        offset <= '0;
                        wb_primed <= 1'b0;
                        if (results[pick_way].victim_valid & results[pick_way].victim_dirty) begin
                            state <= ms_writeback;
                        end else begin
                            state <= ms_refill;
                        end
                    end
                end
                ms_writeback: begin
                    if (!wb_primed) begin
                        wb_primed <= 1'b1;
                        offset <= offset + 1'b1;
                    end else if (beat) begin
                        if (bus_last) begin
                            state <= ms_refill;
                            offset <= '0;
                        end else begin
                            offset <= offset + 1'b1;
                        end
                    end
                end
                ms_refill: begin
                    if (beat) begin
                        offset <= offset + 1'b1;
                        if (bus_last) begin
                            state <= ms_replay;
                        end
                    end
                end
                default: begin
                    state <= ms_idle;
                end
            endcase
        end
    end

    // victim fixed at the miss for the whole burst sequence
    always_ff @(posedge clk) begin
        if ((state == ms_idle) && miss) begin
            vic_way <= pick_way;
            vic_tag <= results[pick_way].victim_tag;
        end
    end

    // bit points at the way to evict next
    always_ff @(posedge clk) begin
        if (resetn) begin
            plru <= '0;
        end else if (any_hit) begin
            plru[idx] <= ~hit_way;
        end else if (fill_done) begin
            plru[idx] <= ~vic_way;
        end
    end

    // refill must never leave the same tag in two ways
    assert property (@(posedge clk) disable iff (resetn) $onehot0(hit_vec))
        else $error("miss_ctrl: more than one way hit");

endmodule

// ==== hw/request_stage.sv ====
`timescale 1ns/1ps

module request_stage import cache_geom_pkg::*; import cache_bus_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     req_valid,
    input  word_t    req_addr,
    input  strobe_t  req_strobe,
    input  word_t    req_wdata,
    input  logic     any_hit,
    input  logic     replay,
    lookup_if.source lookup,
    output cpu_req_t held,
    output logic     addr_ok
);

    logic pending;
    logic cmp;
    logic accept;
    logic load_hit;

    assign accept = req_valid & addr_ok;
    assign load_hit = cmp & any_hit & ~|held.strobe;

    // a store hit leaves one idle cycle behind it
    assign addr_ok = ~pending | load_hit;

    // replay rereads the arrays for the held request
    assign lookup.lookup_en = accept | replay;
    assign lookup.lookup_addr = replay ? held.addr : req_addr;
    assign lookup.lookup_strobe = held.strobe;
    assign lookup.lookup_wdata = held.wdata;
    assign lookup.compare_en = cmp;
    assign lookup.store_ok = cmp & any_hit & |held.strobe;

    always_ff @(posedge clk) begin
        if (resetn) begin
            pending <= 1'b0;
            cmp <= 1'b0;
        end else begin
            cmp <= lookup.lookup_en;
            if (accept) begin
                pending <= 1'b1;
            end else if (cmp & any_hit) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held.addr <= req_addr;
            held.strobe <= req_strobe;
            held.wdata <= req_wdata;
        end
    end

    // a missed request must own the stage until its replay hits
    assert property (@(posedge clk) disable iff (resetn)
        (lookup.compare_en && !any_hit) |-> !lookup.lookup_en)
        else $error("request_stage: new lookup during a miss");

endmodule

// ==== hw/sync_ram.sv ====
`timescale 1ns/1ps

module sync_ram import cache_geom_pkg::*; #(
    parameter int  depth = 128,
    parameter type payload_t = word_t
) (
    input  logic                     clk,
    input  logic                     en,
    input  strobe_t                  we,
    input  logic [$clog2(depth)-1:0] addr,
    input  payload_t                 wdata,
    output payload_t                 rdata
);

    payload_t mem [depth];

    generate
        if ($bits(payload_t) == $bits(word_t)) begin : g_lanes
            always_ff @(posedge clk) begin
                if (en) begin
                    for (int b = 0; b < bytes_per_word; b++) begin
                        if (we[b]) begin
                            mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                        end
                    end
                    // read returns the old contents
                    rdata <= mem[addr];
                end
            end
        end else begin : g_whole
            always_ff @(posedge clk) begin
                if (en) begin
                    if (|we) begin
                        mem[addr] <= wdata;
                    end
                    rdata <= mem[addr];
                end
            end
        end
    endgenerate

    // callers must enable the port for every write
    assert property (@(posedge clk) (we != '0) |-> en)
        else $error("sync_ram: write strobe without enable");

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_top

./obj_dir/Vtb_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
if ! grep -q "All checks passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
